/* hdl/ntt_params_pkg.sv */
//==============================
// Engine and bus constants
// Coefficient sizes, Barrett values and the register map
//==============================

package ntt_params_pkg;

    // Coefficient ring
    localparam int COEF_W = 12;
    localparam int NTT_N  = 16;
    localparam int IDX_W  = 4;
    localparam logic [COEF_W-1:0] NTT_Q = 12'd3329;

    // Unreduced value and Barrett reduction
    localparam int RAW_W      = 24;
    localparam int BARRETT_W  = 13;
    localparam int BARRETT_K  = 24;
    localparam logic [BARRETT_W-1:0] BARRETT_M = 13'd5039;

    // Bus widths
    localparam int BUS_ADDR_W = 8;
    localparam int BUS_DATA_W = 32;

    // Address map, each bank spans 16 words
    localparam logic [BUS_ADDR_W-1:0] ADDR_BANK_A = 8'h00;
    localparam logic [BUS_ADDR_W-1:0] ADDR_BANK_B = 8'h10;
    localparam logic [BUS_ADDR_W-1:0] ADDR_BANK_C = 8'h20;
    localparam logic [BUS_ADDR_W-1:0] ADDR_CTRL   = 8'h30;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SEED   = 8'h31;
    localparam logic [BUS_ADDR_W-1:0] ADDR_STATUS = 8'h32;

    // CTRL and STATUS fields
    localparam int CTRL_START_BIT   = 0;
    localparam int CTRL_MODE_LSB    = 1;
    localparam int CTRL_SHUFFLE_BIT = 3;
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_DONE_BIT  = 1;

    localparam int LFSR_W = 16;

endpackage

/* hdl/ntt_ops_pkg.sv */
//==============================
// Engine operation types
// Pointwise modes and sequencer states
//==============================

package ntt_ops_pkg;

    // Pointwise operation, result always lands in bank C
    typedef enum logic [1:0] {
        MODE_PWM     = 2'd0,
        MODE_PWM_ACC = 2'd1,
        MODE_PWA     = 2'd2,
        MODE_PWS     = 2'd3
    } mode_e;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_DRAIN = 2'd2
    } exec_state_e;

endpackage

/* hdl/ntt_bus_decode.sv */
//==============================
// Register bus decoder
// Bank access, CTRL, seed and STATUS with err pulses
//==============================
`timescale 1ns/1ps

module ntt_bus_decode (
    input  logic                                  hclk,
    input  logic                                  arst_n_i,
    input  logic                                  dv_i,
    input  logic                                  write_i,
    input  logic [ntt_params_pkg::BUS_ADDR_W-1:0] addr_i,
    input  logic [ntt_params_pkg::BUS_DATA_W-1:0] wdata_i,
    input  logic                                  busy_i,
    input  logic                                  done_i,
    input  logic [ntt_params_pkg::COEF_W-1:0]     bus_rdata_i,
    output logic [ntt_params_pkg::BUS_DATA_W-1:0] rdata_o,
    output logic                                  err_o,
    output logic                                  bus_en_o,
    output logic                                  bus_we_o,
    output logic [1:0]                            bus_bank_o,
    output logic [ntt_params_pkg::IDX_W-1:0]      bus_idx_o,
    output logic [ntt_params_pkg::COEF_W-1:0]     bus_wdata_o,
    output logic                                  start_o,
    output ntt_ops_pkg::mode_e                    mode_o,
    output logic                                  shuffle_en_o,
    output logic                                  seed_we_o,
    output logic [ntt_params_pkg::LFSR_W-1:0]     seed_o
);

    logic                                  is_bank;
    logic                                  is_ctrl;
    logic                                  is_seed;
    logic                                  is_status;
    logic                                  bad;
    logic                                  ctrl_wr;
    logic                                  bank_rd_q;
    logic                                  done_q;
    logic [ntt_params_pkg::BUS_DATA_W-1:0] rdata_q;
    logic [ntt_params_pkg::BUS_DATA_W-1:0] status_word;

    assign is_bank   = (addr_i < ntt_params_pkg::ADDR_CTRL);
    assign is_ctrl   = (addr_i == ntt_params_pkg::ADDR_CTRL);
    assign is_seed   = (addr_i == ntt_params_pkg::ADDR_SEED);
    assign is_status = (addr_i == ntt_params_pkg::ADDR_STATUS);
    assign bad       = (is_bank & busy_i) | ~(is_bank | is_ctrl | is_seed | is_status);
    assign ctrl_wr   = dv_i & write_i & is_ctrl & ~busy_i;

    assign bus_en_o    = dv_i & is_bank & ~busy_i;
    assign bus_we_o    = write_i;
    assign bus_bank_o  = addr_i[5:4];
    assign bus_idx_o   = addr_i[3:0];
    assign bus_wdata_o = wdata_i[ntt_params_pkg::COEF_W-1:0];

    assign rdata_o = bank_rd_q ?
                     {{(ntt_params_pkg::BUS_DATA_W-ntt_params_pkg::COEF_W){1'b0}}, bus_rdata_i} :
                     rdata_q;

    always_comb begin
        status_word = '0;
        status_word[ntt_params_pkg::STATUS_BUSY_BIT] = busy_i;
        status_word[ntt_params_pkg::STATUS_DONE_BIT] = done_q;
    end

    always_ff @(posedge hclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_o        <= 1'b0;
            start_o      <= 1'b0;
            mode_o       <= ntt_ops_pkg::MODE_PWM;
            shuffle_en_o <= 1'b0;
            seed_we_o    <= 1'b0;
            seed_o       <= '0;
            bank_rd_q    <= 1'b0;
            done_q       <= 1'b0;
            rdata_q      <= '0;
        end else begin
            err_o     <= dv_i & bad;
            start_o   <= ctrl_wr & wdata_i[ntt_params_pkg::CTRL_START_BIT];
            seed_we_o <= dv_i & write_i & is_seed;
            if (dv_i & write_i & is_seed) begin
                seed_o <= wdata_i[ntt_params_pkg::LFSR_W-1:0];
            end
            if (ctrl_wr) begin
                mode_o       <= ntt_ops_pkg::mode_e'(wdata_i[ntt_params_pkg::CTRL_MODE_LSB +: 2]);
                shuffle_en_o <= wdata_i[ntt_params_pkg::CTRL_SHUFFLE_BIT];
            end
            if (done_i) begin
                done_q <= 1'b1;
            end else if (ctrl_wr & wdata_i[ntt_params_pkg::CTRL_START_BIT]) begin
                done_q <= 1'b0;
            end
            if (dv_i & ~write_i) begin
                bank_rd_q <= is_bank & ~busy_i;
                rdata_q   <= is_status ? status_word : '0;
            end
        end
    end

endmodule

/* hdl/ntt_coef_mem.sv */
//==============================
// Coefficient banks A, B and C
// Bus port to any bank, engine port reads all and writes C
//==============================
`timescale 1ns/1ps

module ntt_coef_mem (
    input  logic                              hclk,
    input  logic                              bus_en_i,
    input  logic                              bus_we_i,
    input  logic [1:0]                        bus_bank_i,
    input  logic [ntt_params_pkg::IDX_W-1:0]  bus_idx_i,
    input  logic [ntt_params_pkg::COEF_W-1:0] bus_wdata_i,
    input  logic                              rd_en_i,
    input  logic [ntt_params_pkg::IDX_W-1:0]  rd_idx_i,
    input  logic                              wr_en_i,
    input  logic [ntt_params_pkg::IDX_W-1:0]  wr_idx_i,
    input  logic [ntt_params_pkg::COEF_W-1:0] wr_data_i,
    output logic [ntt_params_pkg::COEF_W-1:0] bus_rdata_o,
    output logic [ntt_params_pkg::COEF_W-1:0] a_data_o,
    output logic [ntt_params_pkg::COEF_W-1:0] b_data_o,
    output logic [ntt_params_pkg::COEF_W-1:0] c_data_o
);

    logic [ntt_params_pkg::COEF_W-1:0] mem_a [ntt_params_pkg::NTT_N];
    logic [ntt_params_pkg::COEF_W-1:0] mem_b [ntt_params_pkg::NTT_N];
    logic [ntt_params_pkg::COEF_W-1:0] mem_c [ntt_params_pkg::NTT_N];

    logic                              bus_wr;
    logic                              c_we;
    logic [ntt_params_pkg::IDX_W-1:0]  c_widx;
    logic [ntt_params_pkg::COEF_W-1:0] c_wdata;

    assign bus_wr = bus_en_i & bus_we_i;

    // Bank C write port shared by engine write-back and bus
    // The decoder refuses bus bank traffic while the engine runs
    assign c_we    = wr_en_i | (bus_wr && bus_bank_i == 2'd2);
    assign c_widx  = wr_en_i ? wr_idx_i : bus_idx_i;
    assign c_wdata = wr_en_i ? wr_data_i : bus_wdata_i;

    always_ff @(posedge hclk) begin
        if (bus_wr && bus_bank_i == 2'd0) begin
            mem_a[bus_idx_i] <= bus_wdata_i;
        end
        if (bus_wr && bus_bank_i == 2'd1) begin
            mem_b[bus_idx_i] <= bus_wdata_i;
        end
        if (c_we) begin
            mem_c[c_widx] <= c_wdata;
        end
    end

    // Bus read, held until the next bus read
    always_ff @(posedge hclk) begin
        if (bus_en_i && !bus_we_i) begin
            case (bus_bank_i)
                2'd0:    bus_rdata_o <= mem_a[bus_idx_i];
                2'd1:    bus_rdata_o <= mem_b[bus_idx_i];
                default: bus_rdata_o <= mem_c[bus_idx_i];
            endcase
        end
    end

    // Engine read of all three operands at one index
    always_ff @(posedge hclk) begin
        if (rd_en_i) begin
            a_data_o <= mem_a[rd_idx_i];
            b_data_o <= mem_b[rd_idx_i];
            c_data_o <= mem_c[rd_idx_i];
        end
    end

endmodule

/* hdl/ntt_shuffle_lfsr.sv */
//==============================
// Shuffle LFSR
// Fibonacci XNOR, taps 16 15 13 4
//==============================
`timescale 1ns/1ps

module ntt_shuffle_lfsr (
    input  logic                              hclk,
    input  logic                              arst_n_i,
    input  logic                              seed_we_i,
    input  logic [ntt_params_pkg::LFSR_W-1:0] seed_i,
    output logic [ntt_params_pkg::LFSR_W-1:0] state_o
);

    logic feedback;

    // All ones is the lockup state for XNOR feedback
    assign feedback = ~(state_o[15] ^ state_o[14] ^ state_o[12] ^ state_o[3]);

    always_ff @(posedge hclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_o <= '0;
        end else if (seed_we_i) begin
            state_o <= seed_i;
        end else begin
            state_o <= {state_o[ntt_params_pkg::LFSR_W-2:0], feedback};
        end
    end

endmodule

/* hdl/ntt_pw_execute.sv */
//==============================
// Pointwise sequencer
// Issues 16 indices and forms unreduced values
//==============================
`timescale 1ns/1ps

module ntt_pw_execute (
    input  logic                              hclk,
    input  logic                              arst_n_i,
    input  logic                              start_i,
    input  ntt_ops_pkg::mode_e                mode_i,
    input  logic                              shuffle_en_i,
    input  logic [ntt_params_pkg::LFSR_W-1:0] lfsr_i,
    input  logic                              done_i,
    input  logic [ntt_params_pkg::COEF_W-1:0] a_data_i,
    input  logic [ntt_params_pkg::COEF_W-1:0] b_data_i,
    input  logic [ntt_params_pkg::COEF_W-1:0] c_data_i,
    output logic                              busy_o,
    output logic                              rd_en_o,
    output logic [ntt_params_pkg::IDX_W-1:0]  rd_idx_o,
    output logic                              raw_valid_o,
    output logic [ntt_params_pkg::RAW_W-1:0]  raw_value_o,
    output logic [ntt_params_pkg::IDX_W-1:0]  raw_idx_o,
    output logic                              raw_last_o
);

    ntt_ops_pkg::exec_state_e         state_q;
    logic [ntt_params_pkg::IDX_W-1:0] cnt_q;
    logic [ntt_params_pkg::IDX_W-1:0] mask_q;
    logic                             last_issue;

    // Stage 1 tags, aligned with memory data
    logic                             s1_valid_q;
    logic [ntt_params_pkg::IDX_W-1:0] s1_idx_q;
    logic                             s1_last_q;

    logic [ntt_params_pkg::RAW_W-1:0] ab_prod;
    logic [ntt_params_pkg::RAW_W-1:0] raw_d;

    assign busy_o     = (state_q != ntt_ops_pkg::ST_IDLE);
    assign rd_en_o    = (state_q == ntt_ops_pkg::ST_ISSUE);
    assign last_issue = (cnt_q == ntt_params_pkg::IDX_W'(ntt_params_pkg::NTT_N - 1));

    // XOR with a fixed mask keeps the order a permutation
    assign rd_idx_o = cnt_q ^ (shuffle_en_i ? mask_q : '0);

    //==============================
    // Sequencer FSM
    //==============================
    always_ff @(posedge hclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ntt_ops_pkg::ST_IDLE;
            cnt_q   <= '0;
            mask_q  <= '0;
        end else begin
            case (state_q)
                ntt_ops_pkg::ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ntt_ops_pkg::ST_ISSUE;
                        cnt_q   <= '0;
                        mask_q  <= lfsr_i[ntt_params_pkg::IDX_W-1:0];
                    end
                end
                ntt_ops_pkg::ST_ISSUE: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_issue) begin
                        state_q <= ntt_ops_pkg::ST_DRAIN;
                    end
                end
                ntt_ops_pkg::ST_DRAIN: begin
                    // Wait for the last write-back
                    if (done_i) begin
                        state_q <= ntt_ops_pkg::ST_IDLE;
                    end
                end
                default: state_q <= ntt_ops_pkg::ST_IDLE;
            endcase
        end
    end

    //==============================
    // Datapath
    //==============================
    assign ab_prod = a_data_i * b_data_i;

    always_comb begin
        case (mode_i)
            ntt_ops_pkg::MODE_PWM:     raw_d = ab_prod;
            ntt_ops_pkg::MODE_PWM_ACC: raw_d = ab_prod + c_data_i;
            ntt_ops_pkg::MODE_PWA:     raw_d = a_data_i + b_data_i;
            // Offset by q so the difference stays positive
            default:                   raw_d = a_data_i + ntt_params_pkg::NTT_Q - b_data_i;
        endcase
    end

    always_ff @(posedge hclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q  <= 1'b0;
            raw_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= rd_en_o;
            raw_valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge hclk) begin
        s1_idx_q    <= rd_idx_o;
        s1_last_q   <= rd_en_o & last_issue;
        raw_idx_o   <= s1_idx_q;
        raw_last_o  <= s1_last_q;
        raw_value_o <= raw_d;
    end

endmodule

/* hdl/ntt_reduce_result.sv */
//==============================
// Barrett reduction and write-back
// Reduces raw values mod q into bank C
//==============================
`timescale 1ns/1ps

module ntt_reduce_result (
    input  logic                              hclk,
    input  logic                              arst_n_i,
    input  logic                              raw_valid_i,
    input  logic [ntt_params_pkg::RAW_W-1:0]  raw_value_i,
    input  logic [ntt_params_pkg::IDX_W-1:0]  raw_idx_i,
    input  logic                              raw_last_i,
    output logic                              wr_en_o,
    output logic [ntt_params_pkg::IDX_W-1:0]  wr_idx_o,
    output logic [ntt_params_pkg::COEF_W-1:0] wr_data_o,
    output logic                              done_o
);

    logic [ntt_params_pkg::RAW_W+ntt_params_pkg::BARRETT_W-1:0]                         prod;
    logic [ntt_params_pkg::RAW_W+ntt_params_pkg::BARRETT_W-ntt_params_pkg::BARRETT_K-1:0] quot;
    logic [ntt_params_pkg::RAW_W-1:0]  quot_q;
    logic [ntt_params_pkg::RAW_W-1:0]  rem_full;
    logic [ntt_params_pkg::COEF_W:0]   rem;
    logic [ntt_params_pkg::COEF_W:0]   rem_sub;
    logic [ntt_params_pkg::COEF_W-1:0] red_d;

    // Quotient estimate may be short by one, so rem < 2q
    assign prod     = raw_value_i * ntt_params_pkg::BARRETT_M;
    assign quot     = prod[ntt_params_pkg::RAW_W+ntt_params_pkg::BARRETT_W-1:
                           ntt_params_pkg::BARRETT_K];
    assign quot_q   = quot * ntt_params_pkg::NTT_Q;
    assign rem_full = raw_value_i - quot_q;
    assign rem      = rem_full[ntt_params_pkg::COEF_W:0];
    assign rem_sub  = rem - {1'b0, ntt_params_pkg::NTT_Q};

    // Final conditional subtraction
    assign red_d = (rem >= {1'b0, ntt_params_pkg::NTT_Q}) ?
                   rem_sub[ntt_params_pkg::COEF_W-1:0] : rem[ntt_params_pkg::COEF_W-1:0];

    always_ff @(posedge hclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_en_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            wr_en_o <= raw_valid_i;
            done_o  <= raw_valid_i & raw_last_i;
        end
    end

    always_ff @(posedge hclk) begin
        wr_idx_o  <= raw_idx_i;
        wr_data_o <= red_d;
    end

endmodule

/* hdl/ntt_wrapper_fpga.sv */
//==============================
// FPGA wrapper of the pointwise engine
// Register bus in, irq pulse on completion
//==============================
`timescale 1ns/1ps

module ntt_wrapper_fpga (
    input  logic                                  hclk,
    input  logic                                  arst_n_i,
    input  logic                                  dv_i,
    input  logic                                  write_i,
    input  logic [ntt_params_pkg::BUS_ADDR_W-1:0] addr_i,
    input  logic [ntt_params_pkg::BUS_DATA_W-1:0] wdata_i,
    output logic [ntt_params_pkg::BUS_DATA_W-1:0] rdata_o,
    output logic                                  err_o,
    output logic                                  irq_o
);

    // Decoder to memory
    logic                              bus_en;
    logic                              bus_we;
    logic [1:0]                        bus_bank;
    logic [ntt_params_pkg::IDX_W-1:0]  bus_idx;
    logic [ntt_params_pkg::COEF_W-1:0] bus_wdata;
    logic [ntt_params_pkg::COEF_W-1:0] bus_rdata;

    // Control
    logic                              start;
    ntt_ops_pkg::mode_e                mode;
    logic                              shuffle_en;
    logic                              busy;
    logic                              done;
    logic                              seed_we;
    logic [ntt_params_pkg::LFSR_W-1:0] seed;
    logic [ntt_params_pkg::LFSR_W-1:0] lfsr_state;

    // Engine datapath
    logic                              rd_en;
    logic [ntt_params_pkg::IDX_W-1:0]  rd_idx;
    logic [ntt_params_pkg::COEF_W-1:0] a_data;
    logic [ntt_params_pkg::COEF_W-1:0] b_data;
    logic [ntt_params_pkg::COEF_W-1:0] c_data;
    logic                              raw_valid;
    logic [ntt_params_pkg::RAW_W-1:0]  raw_value;
    logic [ntt_params_pkg::IDX_W-1:0]  raw_idx;
    logic                              raw_last;
    logic                              wr_en;
    logic [ntt_params_pkg::IDX_W-1:0]  wr_idx;
    logic [ntt_params_pkg::COEF_W-1:0] wr_data;

    assign irq_o = done;

    ntt_bus_decode ntt_bus_decode_i (
        .hclk         (hclk),
        .arst_n_i     (arst_n_i),
        .dv_i         (dv_i),
        .write_i      (write_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .busy_i       (busy),
        .done_i       (done),
        .bus_rdata_i  (bus_rdata),
        .rdata_o      (rdata_o),
        .err_o        (err_o),
        .bus_en_o     (bus_en),
        .bus_we_o     (bus_we),
        .bus_bank_o   (bus_bank),
        .bus_idx_o    (bus_idx),
        .bus_wdata_o  (bus_wdata),
        .start_o      (start),
        .mode_o       (mode),
        .shuffle_en_o (shuffle_en),
        .seed_we_o    (seed_we),
        .seed_o       (seed)
    );

    ntt_coef_mem ntt_coef_mem_i (
        .hclk        (hclk),
        .bus_en_i    (bus_en),
        .bus_we_i    (bus_we),
        .bus_bank_i  (bus_bank),
        .bus_idx_i   (bus_idx),
        .bus_wdata_i (bus_wdata),
        .rd_en_i     (rd_en),
        .rd_idx_i    (rd_idx),
        .wr_en_i     (wr_en),
        .wr_idx_i    (wr_idx),
        .wr_data_i   (wr_data),
        .bus_rdata_o (bus_rdata),
        .a_data_o    (a_data),
        .b_data_o    (b_data),
        .c_data_o    (c_data)
    );

    ntt_shuffle_lfsr ntt_shuffle_lfsr_i (
        .hclk      (hclk),
        .arst_n_i  (arst_n_i),
        .seed_we_i (seed_we),
        .seed_i    (seed),
        .state_o   (lfsr_state)
    );

    ntt_pw_execute ntt_pw_execute_i (
        .hclk         (hclk),
        .arst_n_i     (arst_n_i),
        .start_i      (start),
        .mode_i       (mode),
        .shuffle_en_i (shuffle_en),
        .lfsr_i       (lfsr_state),
        .done_i       (done),
        .a_data_i     (a_data),
        .b_data_i     (b_data),
        .c_data_i     (c_data),
        .busy_o       (busy),
        .rd_en_o      (rd_en),
        .rd_idx_o     (rd_idx),
        .raw_valid_o  (raw_valid),
        .raw_value_o  (raw_value),
        .raw_idx_o    (raw_idx),
        .raw_last_o   (raw_last)
    );

    ntt_reduce_result ntt_reduce_result_i (
        .hclk        (hclk),
        .arst_n_i    (arst_n_i),
        .raw_valid_i (raw_valid),
        .raw_value_i (raw_value),
        .raw_idx_i   (raw_idx),
        .raw_last_i  (raw_last),
        .wr_en_o     (wr_en),
        .wr_idx_o    (wr_idx),
        .wr_data_o   (wr_data),
        .done_o      (done)
    );

endmodule

/* tb/tb_clock_gen.sv */
//==============================
// Testbench clock source
// 8 ns period, starts low
//==============================
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    localparam real HALF_PERIOD = 4.0;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

/* tb/tb_ntt_wrapper_fpga.sv */
//==============================
// Testbench of the pointwise engine wrapper
// Random banks and modes against a reference model
//==============================
`timescale 1ns/1ps

module tb_ntt_wrapper_fpga;

    localparam int Q = ntt_params_pkg::NTT_Q;
    localparam int N = ntt_params_pkg::NTT_N;

    // Watchdog budget from operations and bank traffic
    localparam int NUM_OPS     = 20;
    localparam int OP_CYCLES   = 40;
    localparam int NUM_LOADS   = 20;
    localparam int LOAD_CYCLES = 3 * 16 * 2 * 2;
    localparam int MAX_CYCLES  = NUM_OPS * OP_CYCLES + NUM_LOADS * LOAD_CYCLES;

    logic        hclk;
    logic        arst_n;
    logic        dv;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
    logic        irq;

    logic [31:0] rng_state;
    int          cycle_cnt;
    int          fail_cnt;
    int          model_a [N];
    int          model_b [N];
    int          model_c [N];

    tb_clock_gen tb_clock_gen_i (
        .clk_o (hclk)
    );

    ntt_wrapper_fpga ntt_wrapper_fpga_i (
        .hclk     (hclk),
        .arst_n_i (arst_n),
        .dv_i     (dv),
        .write_i  (write),
        .addr_i   (addr),
        .wdata_i  (wdata),
        .rdata_o  (rdata),
        .err_o    (err),
        .irq_o    (irq)
    );

    always @(posedge hclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("Test failures found");
            $fatal(1, "Stopped by the cycle watchdog");
        end
    end

    //==============================
    // Helpers
    //==============================
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_cnt++;
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One dv cycle with rdata and err sampled at the next falling edge
    task automatic access_bus(input logic we, input logic [7:0] a, input logic [31:0] d,
                              output logic [31:0] rd, output logic e);
        @(posedge hclk);
        dv    <= 1'b1;
        write <= we;
        addr  <= a;
        wdata <= d;
        @(posedge hclk);
        dv    <= 1'b0;
        write <= 1'b0;
        @(negedge hclk);
        rd = rdata;
        e  = err;
    endtask

    task automatic write_word(input logic [7:0] a, input logic [31:0] d);
        logic [31:0] rd;
        logic        e;
        access_bus(1'b1, a, d, rd, e);
        check_value($sformatf("write 0x%0h err", a), 0, e);
    endtask

    task automatic read_word(input logic [7:0] a, output logic [31:0] rd);
        logic e;
        access_bus(1'b0, a, 32'h0, rd, e);
        check_value($sformatf("read 0x%0h err", a), 0, e);
    endtask

    // Counts cycles until irq, then expects it low again
    task automatic wait_irq(output int n);
        n = 0;
        while (irq !== 1'b1) begin
            @(negedge hclk);
            n++;
        end
        @(negedge hclk);
        check_value("irq single pulse", 0, irq);
    endtask

    task automatic load_banks(input bit with_c);
        for (int i = 0; i < N; i++) begin
            model_a[i] = next_random() % Q;
            model_b[i] = next_random() % Q;
            write_word(ntt_params_pkg::ADDR_BANK_A + 8'(i), model_a[i]);
            write_word(ntt_params_pkg::ADDR_BANK_B + 8'(i), model_b[i]);
            if (with_c) begin
                model_c[i] = next_random() % Q;
                write_word(ntt_params_pkg::ADDR_BANK_C + 8'(i), model_c[i]);
            end
        end
    endtask

    // Reference model in plain integer arithmetic mod q
    task automatic update_model(input ntt_ops_pkg::mode_e m);
        for (int i = 0; i < N; i++) begin
            case (m)
                ntt_ops_pkg::MODE_PWM:     model_c[i] = (model_a[i] * model_b[i]) % Q;
                ntt_ops_pkg::MODE_PWM_ACC: model_c[i] = (model_c[i] + model_a[i] * model_b[i]) % Q;
                ntt_ops_pkg::MODE_PWA:     model_c[i] = (model_a[i] + model_b[i]) % Q;
                default:                   model_c[i] = (model_a[i] - model_b[i] + Q) % Q;
            endcase
        end
    endtask

    function automatic logic [31:0] ctrl_word(input ntt_ops_pkg::mode_e m, input bit shuffle);
        return (32'h1 << ntt_params_pkg::CTRL_START_BIT)
             | (32'(m) << ntt_params_pkg::CTRL_MODE_LSB)
             | (32'(shuffle) << ntt_params_pkg::CTRL_SHUFFLE_BIT);
    endfunction

    task automatic compare_bank_c(input string name);
        logic [31:0] rd;
        for (int i = 0; i < N; i++) begin
            read_word(ntt_params_pkg::ADDR_BANK_C + 8'(i), rd);
            check_value($sformatf("%s C[%0d]", name, i), model_c[i], rd);
        end
    endtask

    task automatic run_op(input ntt_ops_pkg::mode_e m, input bit shuffle, input string name);
        logic [31:0] seed;
        int          n;
        if (shuffle) begin
            seed = next_random();
            write_word(ntt_params_pkg::ADDR_SEED, {16'h0, seed[15:0]});
        end
        update_model(m);
        write_word(ntt_params_pkg::ADDR_CTRL, ctrl_word(m, shuffle));
        wait_irq(n);
        check_value({name, " irq delay"}, 19, n);
        compare_bank_c(name);
    endtask

    //==============================
    // Test sequence
    //==============================
    initial begin
        logic [31:0]        rd;
        logic [31:0]        v;
        logic [7:0]         a;
        logic               e;
        int                 n;
        int                 k;
        ntt_ops_pkg::mode_e mode_v;
        dv        <= 1'b0;
        write     <= 1'b0;
        addr      <= '0;
        wdata     <= '0;
        arst_n    <= 1'b0;
        rng_state = 32'h9785504f;
        fail_cnt  = 0;
        repeat (3) @(posedge hclk);
        arst_n <= 1'b1;

        // Reset values and bank readback over A, B and C
        @(negedge hclk);
        check_value("reset irq", 0, irq);
        check_value("reset err", 0, err);
        read_word(ntt_params_pkg::ADDR_STATUS, rd);
        check_value("reset status", 0, rd);
        for (int i = 0; i < 3 * N; i++) begin
            v = next_random() & 32'hfff;
            write_word(8'(i), v);
            read_word(8'(i), rd);
            check_value($sformatf("bank readback 0x%0h", i), v, rd);
        end

        // Every mode over several vector sets
        for (int m = 0; m < 4; m++) begin
            mode_v = ntt_ops_pkg::mode_e'(m);
            for (int s = 0; s < 3; s++) begin
                load_banks(mode_v == ntt_ops_pkg::MODE_PWM_ACC);
                run_op(mode_v, 1'b0, $sformatf("mode %0d set %0d", m, s));
            end
        end

        // Two accumulations in a row
        load_banks(1'b1);
        run_op(ntt_ops_pkg::MODE_PWM_ACC, 1'b0, "acc first");
        load_banks(1'b0);
        run_op(ntt_ops_pkg::MODE_PWM_ACC, 1'b0, "acc second");

        // Shuffled order with random seeds
        for (int s = 0; s < 4; s++) begin
            v = next_random();
            load_banks(1'b1);
            run_op(ntt_ops_pkg::mode_e'(v[1:0]), 1'b1, $sformatf("shuffle %0d", s));
        end

        // Status during a run and a refused bank write
        load_banks(1'b0);
        v = next_random();
        mode_v = ntt_ops_pkg::mode_e'(v[1:0]);
        update_model(mode_v);
        write_word(ntt_params_pkg::ADDR_CTRL, ctrl_word(mode_v, 1'b0));
        k = next_random() % N;
        access_bus(1'b1, ntt_params_pkg::ADDR_BANK_A + 8'(k), model_a[k] ^ 32'h5a5, rd, e);
        check_value("busy bank write err", 1, e);
        read_word(ntt_params_pkg::ADDR_STATUS, rd);
        check_value("status busy", 32'h1 << ntt_params_pkg::STATUS_BUSY_BIT, rd);
        wait_irq(n);
        read_word(ntt_params_pkg::ADDR_STATUS, rd);
        check_value("status done", 32'h1 << ntt_params_pkg::STATUS_DONE_BIT, rd);
        read_word(ntt_params_pkg::ADDR_BANK_A + 8'(k), rd);
        check_value("busy bank write ignored", model_a[k], rd);
        compare_bank_c("busy run");

        // Unmapped addresses 0x33 to 0xFF
        for (int i = 0; i < 4; i++) begin
            v = next_random();
            a = 8'h33 + 8'(v % 205);
            access_bus(v[31], a, v, rd, e);
            check_value($sformatf("unmapped 0x%0h err", a), 1, e);
        end

        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* ntt_wrapper_fpga.f */
hdl/ntt_params_pkg.sv
hdl/ntt_ops_pkg.sv
hdl/ntt_bus_decode.sv
hdl/ntt_coef_mem.sv
hdl/ntt_shuffle_lfsr.sv
hdl/ntt_pw_execute.sv
hdl/ntt_reduce_result.sv
hdl/ntt_wrapper_fpga.sv
tb/tb_clock_gen.sv
tb/tb_ntt_wrapper_fpga.sv

/* Makefile */
# Verilator build and run of the wrapper testbench

TOP = tb_ntt_wrapper_fpga
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wall -f ntt_wrapper_fpga.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
